/* Makefile */
SOURCES := $(shell cat pcie_app.f)

.PHONY: run clean

run: obj_dir/Vpcie_app_tb
	out=$$(./obj_dir/Vpcie_app_tb); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

obj_dir/Vpcie_app_tb: pcie_app.f $(SOURCES)
	verilator --binary --timing --assert --top-module pcie_app_tb -f pcie_app.f

clean:
	rm -rf obj_dir

/* pcie_app.f */
source/pcie_app_pkg.sv
source/tlp_rx_parser.sv
source/read_request_fifo.sv
source/completion_builder.sv
source/pcie_app.sv
sim/pcie_app_chk.sv
sim/pcie_app_tb.sv

/* sim/pcie_app_chk.sv */
`default_nettype none

module pcie_app_chk
  (
   input logic                   clock,
   input logic                   pcie_reset,
   input logic                   tx_valid,
   input logic                   tx_ready,
   input pcie_app_pkg::tx_beat_t tx_beat,
   input logic                   request_overflow
   );

   timeunit 1ns;
   timeprecision 100ps;

   int assertion_failures = 0;

   // a stalled beat stays put until the core takes it
   assert property (@(posedge clock) disable iff (pcie_reset)
                    tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
   else
   begin
      $error("transmit beat changed while tx_ready was low");
      assertion_failures++;
   end

   assert property (@(posedge clock) disable iff (pcie_reset)
                    tx_valid |-> ((tx_beat.keep == 8'h0F) == tx_beat.last))
   else
   begin
      $error("keep and last disagree on the transmit beat");
      assertion_failures++;
   end

   // sticky overflow
   assert property (@(posedge clock) disable iff (pcie_reset)
                    request_overflow |=> request_overflow)
   else
   begin
      $error("request_overflow cleared without reset");
      assertion_failures++;
   end

endmodule

bind pcie_app pcie_app_chk checks (.*);

`default_nettype wire

/* sim/pcie_app_tb.sv */
`default_nettype none

module pcie_app_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import pcie_app_pkg::*;

   logic          clock = 1'b0;
   logic          pcie_reset;
   logic          rx_valid;
   rx_beat_t      rx_beat;
   logic          tx_ready;
   pcie_id_t      completer_id;
   logic          tx_valid;
   tx_beat_t      tx_beat;
   logic [3:0]    status_leds;
   logic          request_overflow;

   // register and completion model
   logic [63:0]   model_regs [register_count];
   read_request_t expected [$];
   int            beat_index = 0;
   int            ready_mode = 0;
   logic          overflow_seen = 1'b0;
   logic          sent_seen = 1'b0;
   logic [2:0]    last_write = 3'd0;
   logic [63:0]   wanted_data;

   pcie_app uut (.*);

   always #2 clock = ~clock;

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("** FAIL **");
      $fatal(1, "testbench stopped on the first error");
   endtask

   task automatic compare(input string name, input logic [63:0] actual,
                          input logic [63:0] wanted);
      if (actual !== wanted)
         fail_run($sformatf("Mismatch %s: got %h, expected %h", name, actual, wanted));
   endtask

   task automatic next_cycle();
      @(posedge clock);
      #1;
   endtask

   function automatic logic [63:0] rand64();
      return {$urandom, $urandom};
   endfunction

   task automatic send_beat(input logic [63:0] data, input logic last);
      int gap;
      gap = ($urandom_range(3) == 0) ? $urandom_range(2) : 0;
      rx_valid = 1'b0;
      repeat (gap) next_cycle();
      rx_valid = 1'b1;
      rx_beat.data = data;
      rx_beat.last = last;
      next_cycle();
      rx_valid = 1'b0;
   endtask

   task automatic write_register(input reg_addr_t addr, input logic [63:0] value);
      send_beat({$urandom, 1'b0, fmt_type_mwr32, 14'd0, 10'd2}, 1'b0);
      send_beat({value[31:0], 25'($urandom), addr, 3'd0}, 1'b0);
      send_beat({$urandom, value[63:32]}, 1'b1);
      model_regs[addr] = value;
      last_write = value[2:0];
   endtask

   task automatic read_register(input reg_addr_t addr);
      read_request_t entry;
      int            wait_cycles;
      entry.requester_tag = 24'($urandom);
      entry.address = addr;
      entry.data = model_regs[addr];
      send_beat({entry.requester_tag, 8'hFF, 1'b0, fmt_type_mrd32, 14'd0, 10'd2}, 1'b0);
      send_beat({$urandom, 25'($urandom), addr, 3'd0}, 1'b1);
      // four waiting plus the one on the wire is the limit
      if (expected.size() > request_depth)
      begin
         overflow_seen = 1'b1;
         wait_cycles = 0;
         while (!request_overflow && wait_cycles < 10)
         begin
            next_cycle();
            wait_cycles++;
         end
         if (!request_overflow)
            fail_run("request_overflow never rose after a read into a full buffer");
      end
      else
         expected.push_back(entry);
   endtask

   task automatic send_ignored_tlp(input logic is_cpl);
      logic [6:0] fmt;
      int         beats;
      fmt = is_cpl ? fmt_type_cpld : 7'($urandom);
      while (fmt == fmt_type_mwr32 || fmt == fmt_type_mrd32 || (!is_cpl && fmt == fmt_type_cpld))
         fmt = 7'($urandom);
      beats = is_cpl ? 3 + $urandom_range(2) : 1 + $urandom_range(4);
      send_beat({$urandom, 1'b0, fmt, 14'd0, 10'($urandom_range(3))}, beats == 1);
      for (int i = 1; i < beats; i++)
         send_beat(rand64(), i == beats - 1);
   endtask

   task automatic random_traffic(input int count, input logic allow_overflow);
      int kind;
      repeat (count)
      begin
         kind = $urandom_range(9);
         if (kind < 3)
            write_register(4'($urandom), rand64());
         else if (kind < 6 && (allow_overflow || expected.size() < request_depth))
            read_register(4'($urandom));
         else if (kind < 8)
            send_ignored_tlp(kind == 6);
         else
            repeat ($urandom_range(8)) next_cycle();
      end
   endtask

   task automatic drain(input string phase);
      int wait_cycles;
      wait_cycles = 0;
      while (expected.size() != 0 && wait_cycles < 2000)
      begin
         next_cycle();
         wait_cycles++;
      end
      if (expected.size() != 0)
         fail_run($sformatf("completions still missing at the end of %s", phase));
      repeat (4) next_cycle();
      compare("status_leds", 64'(status_leds), {60'd0, sent_seen, last_write});
      compare("request_overflow", 64'(request_overflow), 64'(overflow_seen));
   endtask

   // tx_ready, with long stalls in random mode
   initial
   begin
      int low_hold;
      low_hold = 0;
      tx_ready = 1'b1;
      forever
      begin
         next_cycle();
         if (ready_mode == 2)
            tx_ready = 1'b0;
         else if (ready_mode == 0)
            tx_ready = 1'b1;
         else
         begin
            if (low_hold == 0 && $urandom_range(63) == 0)
               low_hold = 20 + $urandom_range(40);
            if (low_hold > 0)
            begin
               low_hold--;
               tx_ready = 1'b0;
            end
            else
               tx_ready = $urandom_range(3) != 0;
         end
      end
   end

   // transmit monitor
   always @(posedge clock)
   begin
      if (!pcie_reset && tx_valid && tx_ready)
      begin
         if (expected.size() == 0)
            fail_run("completion beat sent with no read outstanding");
         else
         begin
            sent_seen = 1'b1;
            case (beat_index)
               0: wanted_data = {completer_id, 16'(cpl_byte_count),
                                 1'b0, fmt_type_cpld, 14'd0, 10'd2};
               1: wanted_data = {expected[0].data[31:0], expected[0].requester_tag,
                                 1'b0, expected[0].address, 3'd0};
               default: wanted_data = {32'd0, expected[0].data[63:32]};
            endcase
            // upper half of the last beat is not kept
            if (beat_index == 2)
               compare("tx_beat.data", {32'd0, tx_beat.data[31:0]}, wanted_data);
            else
               compare("tx_beat.data", tx_beat.data, wanted_data);
            compare("tx_beat.keep", 64'(tx_beat.keep), beat_index == 2 ? 64'h0F : 64'hFF);
            compare("tx_beat.last", 64'(tx_beat.last), 64'(beat_index == 2));
            if (beat_index == 2)
            begin
               void'(expected.pop_front());
               beat_index = 0;
            end
            else
               beat_index++;
         end
      end
   end

   // assertion failures end the run at once
   always @(posedge clock)
   begin
      if (uut.checks.assertion_failures != 0)
         fail_run("transmit or FIFO assertions failed");
   end

   initial
   begin
      void'($urandom(32173));
      pcie_reset = 1'b1;
      rx_valid = 1'b0;
      rx_beat = '0;
      completer_id = 16'($urandom);
      for (int i = 0; i < register_count; i++)
         model_regs[i] = '0;
      repeat (4) @(posedge clock);
      #1;
      pcie_reset = 1'b0;
      compare("status_leds", 64'(status_leds), 64'd0);
      compare("tx_valid", 64'(tx_valid), 64'd0);
      compare("request_overflow", 64'(request_overflow), 64'd0);
      // unwritten registers read as zero
      for (int i = 0; i < register_count; i++)
      begin
         read_register(reg_addr_t'(i));
         if (i % 4 == 3)
            drain("the zero reads");
      end
      ready_mode = 1;
      random_traffic(400, 1'b0);
      drain("random traffic");
      ready_mode = 2;
      repeat (request_depth + 3) read_register(4'($urandom));
      ready_mode = 1;
      drain("the overflow burst");
      random_traffic(300, 1'b1);
      drain("traffic after overflow");
      if (uut.checks.assertion_failures == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
         fail_run("transmit or FIFO assertions failed");
   end

endmodule

`default_nettype wire

/* source/completion_builder.sv */
`default_nettype none

module completion_builder
  (
   input  logic                        clock,
   input  logic                        pcie_reset,
   input  logic                        pending,
   input  pcie_app_pkg::read_request_t head,
   output logic                        pop,
   input  pcie_app_pkg::pcie_id_t      completer_id,
   input  logic                        tx_ready,
   output logic                        tx_valid,
   output pcie_app_pkg::tx_beat_t      tx_beat,
   output logic                        sent_led
   );

   import pcie_app_pkg::*;

   tx_state_t     tx_state;
   read_request_t request;
   logic          accepted;
   dw_t           cpl_dw0;
   dw_t           cpl_dw1;
   dw_t           cpl_dw2;

   assign accepted = tx_valid && tx_ready;
   // head is taken on the same edge it is popped
   assign pop      = (tx_state == idle) && pending;

   // TC 0, no attributes, length 2
   assign cpl_dw0 = {1'b0, fmt_type_cpld, 14'd0, 10'd2};
   // successful status, byte count of the whole read
   assign cpl_dw1 = {completer_id, 4'd0, 12'(cpl_byte_count)};
   // lower address is the byte address of the register
   assign cpl_dw2 = {request.requester_tag, 1'b0, request.address, 3'd0};

   always_ff @(posedge clock)
   begin
      if (pop)
         request <= head;
   end

   always_ff @(posedge clock)
   begin
      if (pcie_reset)
      begin
         tx_state     <= idle;
         tx_valid     <= 1'b0;
         tx_beat.keep <= 8'hFF;
         tx_beat.last <= 1'b0;
         sent_led     <= 1'b0;
      end
      else
      begin
         if (accepted)
            sent_led <= 1'b1;

         case (tx_state)
            idle:
            begin
               if (pending)
               begin
                  tx_state     <= header;
                  tx_valid     <= 1'b1;
                  tx_beat.data <= {cpl_dw1, cpl_dw0};
                  tx_beat.keep <= 8'hFF;
                  tx_beat.last <= 1'b0;
               end
            end
            header:
            begin
               if (accepted)
               begin
                  tx_state     <= data_low;
                  tx_beat.data <= {request.data[31:0], cpl_dw2};
               end
            end
            data_low:
            begin
               // only the low DWORD of the last beat is valid
               if (accepted)
               begin
                  tx_state     <= data_high;
                  tx_beat.data <= {32'd0, request.data[63:32]};
                  tx_beat.keep <= 8'h0F;
                  tx_beat.last <= 1'b1;
               end
            end
            data_high:
            begin
               if (accepted)
               begin
                  tx_state     <= idle;
                  tx_valid     <= 1'b0;
                  tx_beat.keep <= 8'hFF;
                  tx_beat.last <= 1'b0;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/pcie_app.sv */
`default_nettype none

module pcie_app
  (
   input  logic                   clock,
   input  logic                   pcie_reset,
   input  logic                   rx_valid,
   input  pcie_app_pkg::rx_beat_t rx_beat,
   input  logic                   tx_ready,
   input  pcie_app_pkg::pcie_id_t completer_id,
   output logic                   tx_valid,
   output pcie_app_pkg::tx_beat_t tx_beat,
   output logic [3:0]             status_leds,
   output logic                   request_overflow
   );

   import pcie_app_pkg::*;

   logic          push;
   read_request_t push_request;
   logic          pop;
   logic          pending;
   read_request_t head;
   logic [2:0]    write_leds;
   logic          sent_led;

   // bit 3 completion sent, bits 2:0 last write
   assign status_leds = {sent_led, write_leds};

   tlp_rx_parser parser
     (
      .clock        (clock),
      .pcie_reset   (pcie_reset),
      .rx_valid     (rx_valid),
      .rx_beat      (rx_beat),
      .push         (push),
      .push_request (push_request),
      .write_leds   (write_leds)
      );

   read_request_fifo request_fifo
     (
      .clock        (clock),
      .pcie_reset   (pcie_reset),
      .push         (push),
      .push_request (push_request),
      .pop          (pop),
      .pending      (pending),
      .head         (head),
      .overflow     (request_overflow)
      );

   completion_builder builder
     (
      .clock        (clock),
      .pcie_reset   (pcie_reset),
      .pending      (pending),
      .head         (head),
      .pop          (pop),
      .completer_id (completer_id),
      .tx_ready     (tx_ready),
      .tx_valid     (tx_valid),
      .tx_beat      (tx_beat),
      .sent_led     (sent_led)
      );

endmodule

`default_nettype wire

/* source/pcie_app_pkg.sv */
`default_nettype none

package pcie_app_pkg;

   // widths with a meaning on the TLP streams
   typedef logic [63:0] tlp_beat_t;
   typedef logic [31:0] dw_t;
   typedef logic [3:0]  reg_addr_t;
   typedef logic [23:0] requester_tag_t;
   typedef logic [15:0] pcie_id_t;

   // format/type field, DW0 bits 30:24
   localparam logic [6:0] fmt_type_mwr32 = 7'b1000000;
   localparam logic [6:0] fmt_type_mrd32 = 7'b0000000;
   localparam logic [6:0] fmt_type_cpld  = 7'b1001010;

   localparam int request_depth     = 4;
   localparam int register_count    = 16;
   localparam int cpl_byte_count    = 8;
   localparam int request_ptr_width = $clog2(request_depth);

   typedef logic [request_ptr_width-1:0] request_ptr_t;
   typedef logic [request_ptr_width:0]   request_count_t;

   // receive stream beat from the core
   typedef struct packed
   {
      tlp_beat_t data;
      logic      last;
   } rx_beat_t;

   // transmit stream beat to the core
   typedef struct packed
   {
      tlp_beat_t  data;
      logic [7:0] keep;
      logic       last;
   } tx_beat_t;

   // one queued memory read, data already fetched
   typedef struct packed
   {
      requester_tag_t requester_tag;
      reg_addr_t      address;
      logic [63:0]    data;
   } read_request_t;

   typedef enum logic [1:0]
   {
      header_low,
      header_high,
      payload,
      drain
   } rx_state_t;

   typedef enum logic [1:0]
   {
      idle,
      header,
      data_low,
      data_high
   } tx_state_t;

endpackage

`default_nettype wire

/* source/read_request_fifo.sv */
`default_nettype none

module read_request_fifo
  (
   input  logic                        clock,
   input  logic                        pcie_reset,
   input  logic                        push,
   input  pcie_app_pkg::read_request_t push_request,
   input  logic                        pop,
   output logic                        pending,
   output pcie_app_pkg::read_request_t head,
   output logic                        overflow
   );

   import pcie_app_pkg::*;

   read_request_t  entries [request_depth];
   request_ptr_t   write_ptr;
   request_ptr_t   read_ptr;
   request_count_t count;
   logic           full;
   logic           do_push;
   logic           do_pop;

   function automatic request_ptr_t next_ptr(input request_ptr_t ptr);
      if (ptr == request_ptr_t'(request_depth - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign full    = count == request_count_t'(request_depth);
   assign pending = count != '0;
   assign head    = entries[read_ptr];
   assign do_pop  = pop && pending;
   // a pop in the same cycle frees the slot
   assign do_push = push && (!full || do_pop);

   always_ff @(posedge clock)
   begin
      if (do_push)
         entries[write_ptr] <= push_request;
   end

   always_ff @(posedge clock)
   begin
      if (pcie_reset)
      begin
         write_ptr <= '0;
         read_ptr  <= '0;
         count     <= '0;
         overflow  <= 1'b0;
      end
      else
      begin
         if (do_push)
            write_ptr <= next_ptr(write_ptr);
         if (do_pop)
            read_ptr <= next_ptr(read_ptr);

         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // sticky until reset
         if (push && !do_push)
            overflow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* source/tlp_rx_parser.sv */
`default_nettype none

module tlp_rx_parser
  (
   input  logic                        clock,
   input  logic                        pcie_reset,
   input  logic                        rx_valid,
   input  pcie_app_pkg::rx_beat_t      rx_beat,
   output logic                        push,
   output pcie_app_pkg::read_request_t push_request,
   output logic [2:0]                  write_leds
   );

   import pcie_app_pkg::*;

   rx_state_t      rx_state;
   logic           is_write_32;
   logic           is_read_32;
   logic           is_cpld;
   logic           length_is_2;
   requester_tag_t rx_requester_tag;
   reg_addr_t      rx_address;
   dw_t            previous_dw;
   logic           write_valid;
   logic [63:0]    write_data;
   logic [63:0]    registers [register_count];
   logic [6:0]     fmt_type;
   reg_addr_t      beat_address;

   assign fmt_type     = rx_beat.data[30:24];
   // DW2 sits in the low half of beat 1
   assign beat_address = rx_beat.data[6:3];

   always_ff @(posedge clock)
   begin
      if (pcie_reset)
      begin
         rx_state    <= header_low;
         is_write_32 <= 1'b0;
         is_read_32  <= 1'b0;
         is_cpld     <= 1'b0;
         length_is_2 <= 1'b0;
         write_valid <= 1'b0;
         push        <= 1'b0;
         write_leds  <= 3'd0;
      end
      else
      begin
         if (rx_valid && rx_state == header_low)
         begin
            is_write_32 <= fmt_type == fmt_type_mwr32;
            is_read_32  <= fmt_type == fmt_type_mrd32;
            is_cpld     <= fmt_type == fmt_type_cpld;
            length_is_2 <= rx_beat.data[9:0] == 10'd2;
         end

         if (rx_valid)
         begin
            if (rx_beat.last)
               rx_state <= header_low;
            else
            begin
               case (rx_state)
                  header_low:  rx_state <= header_high;
                  // only writes and completions carry data we walk through
                  header_high: rx_state <= (is_write_32 || is_cpld) ? payload : drain;
                  default:     rx_state <= rx_state;
               endcase
            end
         end

         // beat 2 of a two-DWORD write
         write_valid <= rx_valid && rx_state == payload && is_write_32 && length_is_2;
         push        <= rx_valid && rx_state == header_high && is_read_32 && length_is_2;

         if (write_valid)
            write_leds <= write_data[2:0];
      end
   end

   // header fields and data reassembly
   always_ff @(posedge clock)
   begin
      if (rx_valid)
      begin
         previous_dw <= rx_beat.data[63:32];
         write_data  <= {rx_beat.data[31:0], previous_dw};
         if (rx_state == header_low)
            rx_requester_tag <= rx_beat.data[63:40];
         if (rx_state == header_high)
         begin
            rx_address                 <= beat_address;
            push_request.requester_tag <= rx_requester_tag;
            push_request.address       <= beat_address;
            push_request.data          <= registers[beat_address];
         end
      end
   end

   // register window, reads as zero until written
   always_ff @(posedge clock)
   begin
      if (pcie_reset)
      begin
         for (int i = 0; i < register_count; i++)
            registers[i] <= '0;
      end
      else if (write_valid)
      begin
         registers[rx_address] <= write_data;
      end
   end

endmodule

`default_nettype wire
